// File: lsu_top.f
src/lsu_pkg.sv
src/lsu_op_decode.sv
src/lsu_req_stage.sv
src/lsu_mem_stage.sv
src/lsu_load_align.sv
src/lsu_top.sv
test/lsu_top_sva.sv
test/lsu_top_tb.sv

// File: src/lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
   input  wire [lsu_pkg::xlen-1:0]      rdata,
   input  wire [1:0]                    addr_lo,
   input  wire lsu_pkg::lsu_size_e      size,
   input  wire                          is_unsigned,
   input  wire                          is_sc,
   input  wire                          sc_succeed,
   output logic [lsu_pkg::xlen-1:0]     result
);

   logic [7:0]  byte_sel;
   logic [15:0] half_sel;

   // byte lane picked by the low address bits
   always_comb begin
      case (addr_lo)
         2'b00:   byte_sel = rdata[7:0];
         2'b01:   byte_sel = rdata[15:8];
         2'b10:   byte_sel = rdata[23:16];
         default: byte_sel = rdata[31:24];
      endcase
   end

   // halfword lane from bit 1 only
   assign half_sel = addr_lo[1] ? rdata[31:16] : rdata[15:0];

   always_comb begin
      case (size)
         lsu_pkg::size_byte: begin
            if (is_unsigned) begin
               result = {{(lsu_pkg::xlen-8){1'b0}}, byte_sel};
            end else begin
               result = {{(lsu_pkg::xlen-8){byte_sel[7]}}, byte_sel};
            end
         end
         lsu_pkg::size_half: begin
            if (is_unsigned) begin
               result = {{(lsu_pkg::xlen-16){1'b0}}, half_sel};
            end else begin
               result = {{(lsu_pkg::xlen-16){half_sel[15]}}, half_sel};
            end
         end
         default: begin
            result = rdata;
         end
      endcase
      // sc writes back only its success flag
      if (is_sc) begin
         result = {{(lsu_pkg::xlen-1){1'b0}}, sc_succeed};
      end
   end

endmodule

`default_nettype wire

// File: src/lsu_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_stage #(
   parameter int reg_addr_w = 5
) (
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire                          valid_e,
   input  wire                          ale_e,
   input  wire lsu_pkg::lsu_op_e        op_e,
   input  wire [lsu_pkg::xlen-1:0]      addr_e,
   input  wire [reg_addr_w-1:0]         rd_e,
   input  wire                          wen_e,
   input  wire                          data_addr_ok,
   input  wire                          data_data_ok_m,
   output lsu_pkg::lsu_op_e             op_m,
   output logic [lsu_pkg::xlen-1:0]     addr_m,
   output logic [reg_addr_w-1:0]        rd_m,
   output logic                         wen_m,
   output logic                         data_recv,
   output logic                         finish_m
);

   logic valid_m;
   logic ale_m;

   // operation control carried into the memory stage
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_m <= 1'b0;
         ale_m   <= 1'b0;
         op_m    <= lsu_pkg::op_nop;
         wen_m   <= 1'b0;
      end else begin
         valid_m <= valid_e;
         if (valid_e) begin
            ale_m <= ale_e;
            op_m  <= op_e;
            wen_m <= wen_e;
         end
      end
   end

   // address and destination held until the next operation
   always_ff @(posedge clk) begin
      if (valid_e) begin
         addr_m <= addr_e;
         rd_m   <= rd_e;
      end
   end

   // pending read data, set by address accept and cleared by data return
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         data_recv <= 1'b0;
      end else begin
         data_recv <= (data_recv | data_addr_ok) & ~data_data_ok_m;
      end
   end

   // a faulting access never reaches memory, so it finishes on its own
   // one cycle after valid_e
   assign finish_m = data_data_ok_m | (ale_m & valid_m);

endmodule

`default_nettype wire

// File: src/lsu_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_op_decode (
   input  wire lsu_pkg::lsu_op_e    op,
   output lsu_pkg::lsu_size_e       size,
   output logic                     is_unsigned,
   output logic                     is_load,
   output logic                     is_store,
   output logic                     is_ll,
   output logic                     is_sc
);

   // one table for all access classes
   always_comb begin
      size        = lsu_pkg::size_word;
      is_unsigned = 1'b0;
      is_load     = 1'b0;
      is_store    = 1'b0;
      is_ll       = 1'b0;
      is_sc       = 1'b0;
      case (op)
         lsu_pkg::op_ld_b: begin
            size    = lsu_pkg::size_byte;
            is_load = 1'b1;
         end
         lsu_pkg::op_ld_h: begin
            size    = lsu_pkg::size_half;
            is_load = 1'b1;
         end
         lsu_pkg::op_ld_w: begin
            is_load = 1'b1;
         end
         lsu_pkg::op_ld_bu: begin
            size        = lsu_pkg::size_byte;
            is_unsigned = 1'b1;
            is_load     = 1'b1;
         end
         lsu_pkg::op_ld_hu: begin
            size        = lsu_pkg::size_half;
            is_unsigned = 1'b1;
            is_load     = 1'b1;
         end
         lsu_pkg::op_st_b: begin
            size     = lsu_pkg::size_byte;
            is_store = 1'b1;
         end
         lsu_pkg::op_st_h: begin
            size     = lsu_pkg::size_half;
            is_store = 1'b1;
         end
         lsu_pkg::op_st_w: begin
            is_store = 1'b1;
         end
         // ll reads memory, sc writes it
         lsu_pkg::op_ll_w: begin
            is_load = 1'b1;
            is_ll   = 1'b1;
         end
         lsu_pkg::op_sc_w: begin
            is_store = 1'b1;
            is_sc    = 1'b1;
         end
         default: begin
            size = lsu_pkg::size_word;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

   // data path and address width, the lane logic is built around it
   localparam int xlen = 32;

   // memory operation codes presented by the execute stage
   typedef enum logic [3:0] {
      op_ld_b  = 4'd0,
      op_ld_h  = 4'd1,
      op_ld_w  = 4'd2,
      op_ld_bu = 4'd3,
      op_ld_hu = 4'd4,
      op_st_b  = 4'd5,
      op_st_h  = 4'd6,
      op_st_w  = 4'd7,
      // load-linked and store-conditional, word only
      op_ll_w  = 4'd8,
      op_sc_w  = 4'd9,
      op_nop   = 4'd15
   } lsu_op_e;

   // access size of one memory operation
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } lsu_size_e;

endpackage

`default_nettype wire

// File: src/lsu_req_stage.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_req_stage #(
   parameter bit align_check = 1'b1
) (
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire                          valid_e,
   input  wire [lsu_pkg::xlen-1:0]      base,
   input  wire [lsu_pkg::xlen-1:0]      offset,
   input  wire [lsu_pkg::xlen-1:0]      wdata,
   input  wire lsu_pkg::lsu_size_e      size,
   input  wire                          is_store,
   input  wire                          is_ll,
   input  wire                          is_sc,
   output logic                         ale_e,
   output logic [lsu_pkg::xlen-1:0]     badv_e,
   output logic                         data_req,
   output logic                         data_wr,
   output logic                         data_ll,
   output logic                         data_sc,
   output logic [lsu_pkg::xlen-1:0]     data_addr,
   output logic [lsu_pkg::xlen-1:0]     data_wdata,
   output logic [3:0]                   data_wstrb
);

   logic [lsu_pkg::xlen-1:0] addr;
   logic [1:0]               shift;
   logic                     ord_misalign;
   logic                     excl_misalign;
   logic                     req_in;
   logic [3:0]               wstrb_in;
   logic [lsu_pkg::xlen-1:0] wdata_in;

   assign addr  = base + offset;
   assign shift = addr[1:0];

   // ordinary accesses, checked only when the core enables it
   always_comb begin
      case (size)
         lsu_pkg::size_word: ord_misalign = (shift != 2'b00);
         lsu_pkg::size_half: ord_misalign = shift[0];
         default:            ord_misalign = 1'b0;
      endcase
   end

   // ll and sc are word accesses and always checked
   assign excl_misalign = (is_ll | is_sc) & (shift != 2'b00);

   assign ale_e  = valid_e & (excl_misalign | (align_check & ord_misalign));
   assign badv_e = addr;

   // no request goes out for a faulting access
   assign req_in = valid_e & ~ale_e;

   // byte enables by size and lane
   always_comb begin
      case (size)
         lsu_pkg::size_byte: wstrb_in = 4'b0001 << shift;
         lsu_pkg::size_half: wstrb_in = 4'b0011 << shift;
         default:            wstrb_in = 4'b1111;
      endcase
   end

   // store data repeated over every lane of its size
   always_comb begin
      case (size)
         lsu_pkg::size_byte: wdata_in = {4{wdata[7:0]}};
         lsu_pkg::size_half: wdata_in = {2{wdata[15:0]}};
         default:            wdata_in = wdata;
      endcase
   end

   // request valid and its flags
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         data_req <= 1'b0;
         data_wr  <= 1'b0;
         data_ll  <= 1'b0;
         data_sc  <= 1'b0;
      end else begin
         data_req <= req_in;
         data_wr  <= req_in & is_store;
         data_ll  <= req_in & is_ll;
         data_sc  <= req_in & is_sc;
      end
   end

   // request payload, qualified by data_req
   always_ff @(posedge clk) begin
      data_addr  <= addr;
      data_wstrb <= wstrb_in;
      data_wdata <= wdata_in;
   end

endmodule

`default_nettype wire

// File: src/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
   parameter int reg_addr_w  = 5,
   parameter bit align_check = 1'b1
) (
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire                          valid_e,
   input  wire lsu_pkg::lsu_op_e        lsu_op,
   input  wire [lsu_pkg::xlen-1:0]      base,
   input  wire [lsu_pkg::xlen-1:0]      offset,
   input  wire [lsu_pkg::xlen-1:0]      wdata,
   input  wire [reg_addr_w-1:0]         ecl_lsu_rd_e,
   input  wire                          ecl_lsu_wen_e,
   // memory port
   output logic                         data_req,
   output logic [lsu_pkg::xlen-1:0]     data_addr,
   output logic                         data_wr,
   output logic [3:0]                   data_wstrb,
   output logic [lsu_pkg::xlen-1:0]     data_wdata,
   output logic                         data_ll,
   output logic                         data_sc,
   input  wire                          data_addr_ok,
   output logic                         data_recv,
   input  wire                          data_scsucceed,
   input  wire [lsu_pkg::xlen-1:0]      data_rdata_m,
   input  wire                          data_data_ok_m,
   // results to the core
   output logic [lsu_pkg::xlen-1:0]     read_result_m,
   output logic                         lsu_finish_m,
   output logic [reg_addr_w-1:0]        lsu_ecl_rd_m,
   output logic                         lsu_ecl_wen_m,
   output logic                         lsu_ecl_ale_e,
   output logic [lsu_pkg::xlen-1:0]     lsu_csr_badv_e
);

   lsu_pkg::lsu_size_e       size_e;
   logic                     store_e;
   logic                     ll_e;
   logic                     sc_e;
   lsu_pkg::lsu_op_e         op_m;
   logic [lsu_pkg::xlen-1:0] addr_m;
   lsu_pkg::lsu_size_e       size_m;
   logic                     unsigned_m;
   logic                     sc_m;

   // execute stage decode
   lsu_op_decode dec_e (
      .op          (lsu_op),
      .size        (size_e),
      .is_unsigned (),
      .is_load     (),
      .is_store    (store_e),
      .is_ll       (ll_e),
      .is_sc       (sc_e)
   );

   lsu_req_stage #(
      .align_check (align_check)
   ) u_req (
      .clk        (clk),
      .arst_n     (arst_n),
      .valid_e    (valid_e),
      .base       (base),
      .offset     (offset),
      .wdata      (wdata),
      .size       (size_e),
      .is_store   (store_e),
      .is_ll      (ll_e),
      .is_sc      (sc_e),
      .ale_e      (lsu_ecl_ale_e),
      .badv_e     (lsu_csr_badv_e),
      .data_req   (data_req),
      .data_wr    (data_wr),
      .data_ll    (data_ll),
      .data_sc    (data_sc),
      .data_addr  (data_addr),
      .data_wdata (data_wdata),
      .data_wstrb (data_wstrb)
   );

   lsu_mem_stage #(
      .reg_addr_w (reg_addr_w)
   ) u_mem (
      .clk            (clk),
      .arst_n         (arst_n),
      .valid_e        (valid_e),
      .ale_e          (lsu_ecl_ale_e),
      .op_e           (lsu_op),
      .addr_e         (lsu_csr_badv_e),
      .rd_e           (ecl_lsu_rd_e),
      .wen_e          (ecl_lsu_wen_e),
      .data_addr_ok   (data_addr_ok),
      .data_data_ok_m (data_data_ok_m),
      .op_m           (op_m),
      .addr_m         (addr_m),
      .rd_m           (lsu_ecl_rd_m),
      .wen_m          (lsu_ecl_wen_m),
      .data_recv      (data_recv),
      .finish_m       (lsu_finish_m)
   );

   // memory stage decode of the held operation
   lsu_op_decode dec_m (
      .op          (op_m),
      .size        (size_m),
      .is_unsigned (unsigned_m),
      .is_load     (),
      .is_store    (),
      .is_ll       (),
      .is_sc       (sc_m)
   );

   lsu_load_align u_align (
      .rdata       (data_rdata_m),
      .addr_lo     (addr_m[1:0]),
      .size        (size_m),
      .is_unsigned (unsigned_m),
      .is_sc       (sc_m),
      .sc_succeed  (data_scsucceed),
      .result      (read_result_m)
   );

endmodule

`default_nettype wire

// File: test/lsu_golden.txt
# op base offset wdata rd wen rdata scok | ale addr wstrb wdata wr ll sc result
# every field hex, the columns after scok are the expected outputs
7 00001000 00000004 deadbeef 01 0 00000000 0 0 00001004 f deadbeef 1 0 0 00000000
6 00001000 00000000 1234abcd 02 0 00000000 0 0 00001000 3 abcdabcd 1 0 0 00000000
6 00001000 00000002 00005a5a 03 0 00000000 0 0 00001002 c 5a5a5a5a 1 0 0 00000000
5 00001000 00000000 000000e7 04 0 00000000 0 0 00001000 1 e7e7e7e7 1 0 0 00000000
5 00002000 00000003 ffffff3c 05 0 00000000 0 0 00002003 8 3c3c3c3c 1 0 0 00000000
5 00002001 00000000 00000081 06 0 00000000 0 0 00002001 2 81818181 1 0 0 00000000
0 00003000 00000000 00000000 07 1 80f17f92 0 0 00003000 0 00000000 0 0 0 ffffff92
0 00003000 00000001 00000000 08 1 80f17f92 0 0 00003001 0 00000000 0 0 0 0000007f
0 00003000 00000002 00000000 09 1 80f17f92 0 0 00003002 0 00000000 0 0 0 fffffff1
0 00003000 00000003 00000000 0f 1 80f17f92 0 0 00003003 0 00000000 0 0 0 ffffff80
3 00003000 00000003 00000000 0a 1 80f17f92 0 0 00003003 0 00000000 0 0 0 00000080
3 00003000 00000000 00000000 0b 1 80f17f92 0 0 00003000 0 00000000 0 0 0 00000092
1 00003000 00000000 00000000 0c 1 80f17f92 0 0 00003000 0 00000000 0 0 0 00007f92
1 00003000 00000002 00000000 0d 1 80f17f92 0 0 00003002 0 00000000 0 0 0 ffff80f1
4 00003000 00000002 00000000 0e 1 80f17f92 0 0 00003002 0 00000000 0 0 0 000080f1
2 00004010 fffffff0 00000000 10 1 80f17f92 0 0 00004000 0 00000000 0 0 0 80f17f92
8 00005000 00000008 00000000 11 1 13579bdf 0 0 00005008 0 00000000 0 1 0 13579bdf
9 00005000 00000008 2468ace0 12 1 00000000 1 0 00005008 f 2468ace0 1 0 1 00000001
9 00005000 00000008 2468ace0 13 1 ffffffff 0 0 00005008 f 2468ace0 1 0 1 00000000
2 00006000 00000002 00000000 14 1 00000000 0 1 00006002 0 00000000 0 0 0 00000000
6 00006001 00000000 0000beef 15 0 00000000 0 1 00006001 0 00000000 0 0 0 00000000
8 00006004 00000001 00000000 16 1 00000000 0 1 00006005 0 00000000 0 0 0 00000000
7 00007000 00000003 cafef00d 17 0 00000000 0 1 00007003 0 00000000 0 0 0 00000000

// File: test/lsu_top_sva.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top_sva (
   input wire clk,
   input wire arst_n,
   input wire valid_e,
   input wire lsu_ecl_ale_e,
   input wire data_req,
   input wire data_addr_ok,
   input wire data_recv
);

   // a faulting access never reaches the memory port
   no_req_after_ale: assert property (
      @(posedge clk) disable iff (!arst_n) lsu_ecl_ale_e |=> !data_req
   ) else $error("data_req issued after a misaligned access");

   // the exception is only raised for a presented operation
   ale_needs_valid: assert property (
      @(posedge clk) disable iff (!arst_n) lsu_ecl_ale_e |-> valid_e
   ) else $error("lsu_ecl_ale_e high without valid_e");

   // receive pending only starts after an accepted address
   recv_after_addr_ok: assert property (
      @(posedge clk) disable iff (!arst_n) $rose(data_recv) |-> $past(data_addr_ok)
   ) else $error("data_recv rose without a prior data_addr_ok");

endmodule

bind lsu_top lsu_top_sva u_sva (
   .clk           (clk),
   .arst_n        (arst_n),
   .valid_e       (valid_e),
   .lsu_ecl_ale_e (lsu_ecl_ale_e),
   .data_req      (data_req),
   .data_addr_ok  (data_addr_ok),
   .data_recv     (data_recv)
);

`default_nettype wire

// File: test/lsu_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top_tb;

   localparam int reg_addr_w  = 5;
   localparam int max_vectors = 64;

   logic                  clk;
   logic                  arst_n;
   logic                  valid_e;
   lsu_pkg::lsu_op_e      lsu_op;
   logic [31:0]           base;
   logic [31:0]           offset;
   logic [31:0]           wdata;
   logic [reg_addr_w-1:0] ecl_lsu_rd_e;
   logic                  ecl_lsu_wen_e;
   logic                  data_req;
   logic [31:0]           data_addr;
   logic                  data_wr;
   logic [3:0]            data_wstrb;
   logic [31:0]           data_wdata;
   logic                  data_ll;
   logic                  data_sc;
   logic                  data_addr_ok;
   logic                  data_recv;
   logic                  data_scsucceed;
   logic [31:0]           data_rdata_m;
   logic                  data_data_ok_m;
   logic [31:0]           read_result_m;
   logic                  lsu_finish_m;
   logic [reg_addr_w-1:0] lsu_ecl_rd_m;
   logic                  lsu_ecl_wen_m;
   logic                  lsu_ecl_ale_e;
   logic [31:0]           lsu_csr_badv_e;

   logic [31:0] vectors [0:max_vectors-1][0:15];
   int          num_vectors;
   int          error_count;
   int          cycle_count;
   int          cycle_limit;
   integer      seed;

   lsu_top #(
      .reg_addr_w  (reg_addr_w),
      .align_check (1'b1)
   ) DUT (
      .clk            (clk),
      .arst_n         (arst_n),
      .valid_e        (valid_e),
      .lsu_op         (lsu_op),
      .base           (base),
      .offset         (offset),
      .wdata          (wdata),
      .ecl_lsu_rd_e   (ecl_lsu_rd_e),
      .ecl_lsu_wen_e  (ecl_lsu_wen_e),
      .data_req       (data_req),
      .data_addr      (data_addr),
      .data_wr        (data_wr),
      .data_wstrb     (data_wstrb),
      .data_wdata     (data_wdata),
      .data_ll        (data_ll),
      .data_sc        (data_sc),
      .data_addr_ok   (data_addr_ok),
      .data_recv      (data_recv),
      .data_scsucceed (data_scsucceed),
      .data_rdata_m   (data_rdata_m),
      .data_data_ok_m (data_data_ok_m),
      .read_result_m  (read_result_m),
      .lsu_finish_m   (lsu_finish_m),
      .lsu_ecl_rd_m   (lsu_ecl_rd_m),
      .lsu_ecl_wen_m  (lsu_ecl_wen_m),
      .lsu_ecl_ale_e  (lsu_ecl_ale_e),
      .lsu_csr_badv_e (lsu_csr_badv_e)
   );

   always #50 clk = ~clk;

   // watchdog over the whole run
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("timeout: the run did not end within %0d cycles", cycle_limit);
         $display("Result: FAILED");
         $finish;
      end
   end

   task automatic report_mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count = error_count + 1;
   endtask

   // memory port and finish strobe must be quiet
   task automatic check_quiet(input string when);
      if (data_req !== 1'b0) report_mismatch({"data_req ", when}, data_req, 0);
      if (data_recv !== 1'b0) report_mismatch({"data_recv ", when}, data_recv, 0);
      if (lsu_finish_m !== 1'b0) report_mismatch({"lsu_finish_m ", when}, lsu_finish_m, 0);
   endtask

   task automatic load_vectors();
      int          fd;
      int          code;
      string       line;
      logic [31:0] f [0:15];
      fd = $fopen("test/lsu_golden.txt", "r");
      if (fd == 0) begin
         $display("could not open test/lsu_golden.txt");
         error_count = error_count + 1;
      end else begin
         while ($fgets(line, fd) != 0) begin
            // comment lines give no fields
            code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                           f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
            if (code == 16 && num_vectors < max_vectors) begin
               for (int i = 0; i < 16; i++) begin
                  vectors[num_vectors][i] = f[i];
               end
               num_vectors = num_vectors + 1;
            end else if (code > 0) begin
               $display("golden file line not usable: %s", line);
               error_count = error_count + 1;
            end
         end
         $fclose(fd);
      end
      if (num_vectors == 0) begin
         $display("no vectors found in the golden file");
         error_count = error_count + 1;
      end
   endtask

   task automatic run_vector(input int n);
      logic [reg_addr_w-1:0] exp_rd;
      logic                  exp_wen;
      logic                  exp_ale;
      logic                  exp_wr;
      int                    addr_ok_cyc;
      int                    data_cyc;
      int                    c;
      exp_rd  = vectors[n][4][reg_addr_w-1:0];
      exp_wen = vectors[n][5][0];
      exp_ale = vectors[n][8][0];
      exp_wr  = vectors[n][12][0];
      // execute cycle
      @(posedge clk);
      #5;
      valid_e       = 1'b1;
      lsu_op        = lsu_pkg::lsu_op_e'(vectors[n][0][3:0]);
      base          = vectors[n][1];
      offset        = vectors[n][2];
      wdata         = vectors[n][3];
      ecl_lsu_rd_e  = exp_rd;
      ecl_lsu_wen_e = exp_wen;
      @(negedge clk);
      if (lsu_ecl_ale_e !== exp_ale) report_mismatch("lsu_ecl_ale_e", lsu_ecl_ale_e, exp_ale);
      if (lsu_csr_badv_e !== vectors[n][9]) begin
         report_mismatch("lsu_csr_badv_e", lsu_csr_badv_e, vectors[n][9]);
      end
      if (lsu_finish_m !== 1'b0) report_mismatch("lsu_finish_m in execute", lsu_finish_m, 0);
      @(posedge clk);
      #5;
      valid_e = 1'b0;
      @(negedge clk);
      if (exp_ale) begin
         // faulting access finishes on its own one cycle later
         if (data_req !== 1'b0) report_mismatch("data_req after fault", data_req, 0);
         if (lsu_finish_m !== 1'b1) report_mismatch("lsu_finish_m after fault", lsu_finish_m, 1);
      end else begin
         if (data_req !== 1'b1) report_mismatch("data_req", data_req, 1);
         if (data_addr !== vectors[n][9]) report_mismatch("data_addr", data_addr, vectors[n][9]);
         if (data_wr !== exp_wr) report_mismatch("data_wr", data_wr, exp_wr);
         if (data_ll !== vectors[n][13][0]) report_mismatch("data_ll", data_ll, vectors[n][13]);
         if (data_sc !== vectors[n][14][0]) report_mismatch("data_sc", data_sc, vectors[n][14]);
         if (exp_wr && data_wstrb !== vectors[n][10][3:0]) begin
            report_mismatch("data_wstrb", data_wstrb, vectors[n][10]);
         end
         if (exp_wr && data_wdata !== vectors[n][11]) begin
            report_mismatch("data_wdata", data_wdata, vectors[n][11]);
         end
         // memory responder with random accept and return delays
         addr_ok_cyc = 2 + ({$random(seed)} % 3);
         data_cyc    = addr_ok_cyc + 1 + ({$random(seed)} % 3);
         for (c = 2; c <= data_cyc; c++) begin
            @(posedge clk);
            #5;
            data_addr_ok   = (c == addr_ok_cyc);
            data_data_ok_m = (c == data_cyc);
            data_rdata_m   = (c == data_cyc) ? vectors[n][6] : 32'h0;
            data_scsucceed = (c == data_cyc) ? vectors[n][7][0] : 1'b0;
            @(negedge clk);
            if (data_req !== 1'b0) report_mismatch("data_req repeated", data_req, 0);
            if (data_recv !== (c > addr_ok_cyc)) begin
               report_mismatch("data_recv", data_recv, c > addr_ok_cyc);
            end
            if (lsu_finish_m !== (c == data_cyc)) begin
               report_mismatch("lsu_finish_m", lsu_finish_m, c == data_cyc);
            end
         end
         if (read_result_m !== vectors[n][15]) begin
            report_mismatch("read_result_m", read_result_m, vectors[n][15]);
         end
      end
      if (lsu_ecl_rd_m !== exp_rd) report_mismatch("lsu_ecl_rd_m", lsu_ecl_rd_m, exp_rd);
      if (lsu_ecl_wen_m !== exp_wen) report_mismatch("lsu_ecl_wen_m", lsu_ecl_wen_m, exp_wen);
      // one idle cycle before the next operation
      @(posedge clk);
      #5;
      data_addr_ok   = 1'b0;
      data_data_ok_m = 1'b0;
      data_rdata_m   = 32'h0;
      data_scsucceed = 1'b0;
      @(negedge clk);
      check_quiet("after finish");
   endtask

   initial begin
      seed           = 32'hc315e8ea;
      clk            = 1'b0;
      arst_n         = 1'b0;
      valid_e        = 1'b0;
      lsu_op         = lsu_pkg::op_nop;
      base           = 32'h0;
      offset         = 32'h0;
      wdata          = 32'h0;
      ecl_lsu_rd_e   = '0;
      ecl_lsu_wen_e  = 1'b0;
      data_addr_ok   = 1'b0;
      data_scsucceed = 1'b0;
      data_rdata_m   = 32'h0;
      data_data_ok_m = 1'b0;
      error_count    = 0;
      cycle_count    = 0;
      num_vectors    = 0;
      cycle_limit    = 20;
      load_vectors();
      cycle_limit = 12 * num_vectors + 20;
      // reset over three rising edges
      repeat (2) begin
         @(negedge clk);
         check_quiet("in reset");
      end
      @(posedge clk);
      #5;
      arst_n = 1'b1;
      @(negedge clk);
      check_quiet("after reset");
      for (int n = 0; n < num_vectors; n++) begin
         run_vector(n);
      end
      $display("vectors run: %0d, errors: %0d", num_vectors, error_count);
      if (error_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
